// ==== source/valu_pkg.sv ====
package valu_pkg;

  // element widths
  parameter int byte_width  = 8;
  parameter int hword_width = 16;
  parameter int word_width  = 32;

  // scalar register width
  parameter int xlen = 32;

  parameter int rob_tag_width = 3;

  typedef enum logic [1:0] {
    eew8  = 2'd0,
    eew16 = 2'd1,
    eew32 = 2'd2
  } eew_e;

  typedef enum logic [3:0] {
    op_minu     = 4'd0,
    op_min      = 4'd1,
    op_maxu     = 4'd2,
    op_max      = 4'd3,
    op_merge_mv = 4'd4,
    op_zext2    = 4'd5,
    op_sext2    = 4'd6,
    op_zext4    = 4'd7,
    op_sext4    = 4'd8,
    op_mv_x_s   = 4'd9,
    op_mv_s_x   = 4'd10
  } alu_op_e;

  // scalar also covers immediates
  typedef enum logic {
    src_vector = 1'b0,
    src_scalar = 1'b1
  } src_e;

  typedef enum logic [2:0] {
    res_none   = 3'd0,
    res_minmax = 3'd1,
    res_merge  = 3'd2,
    res_src1   = 3'd3,
    res_src2   = 3'd4,
    res_extend = 3'd5
  } res_sel_e;

endpackage

// ==== source/valu_operand_prep.sv ====
`timescale 1ns/1ps

module valu_operand_prep import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  alu_op_e         op,
  input  src_e            src,
  input  eew_e            eew,
  input  logic            vm,
  input  logic [1:0]      uop_index,
  input  logic [vlen-1:0] vs1_data,
  input  logic [vlen-1:0] vs2_data,
  input  logic [xlen-1:0] rs1_data,
  output logic [vlen-1:0] src1,
  output logic [vlen-1:0] src2,
  output logic            is_signed,
  output logic            take_max,
  output logic            ext_factor4,
  output res_sel_e        res_sel,
  output logic            ignore_vma
);

  localparam int half    = vlen / 2;
  localparam int quarter = vlen / 4;

  logic [word_width-1:0] rs1_bcast_word;
  logic [word_width-1:0] rs1_elem0;
  logic [word_width-1:0] vs2_elem0;
  logic                  is_ext;

  // keep the low eew bits, zero above
  function automatic logic [word_width-1:0] low_elem(input logic [word_width-1:0] d,
                                                     input eew_e e);
    logic [word_width-1:0] r;
    r = '0;
    case (e)
      eew8:    r[byte_width-1:0]  = d[byte_width-1:0];
      eew16:   r[hword_width-1:0] = d[hword_width-1:0];
      default: r = d;
    endcase
    return r;
  endfunction

  assign rs1_elem0 = low_elem(rs1_data, eew);
  assign vs2_elem0 = low_elem(vs2_data[word_width-1:0], eew);
  assign is_ext    = op inside {op_zext2, op_sext2, op_zext4, op_sext4};

  // scalar replicated into one 32-bit word
  always_comb begin
    case (eew)
      eew8:    rs1_bcast_word = {(word_width/byte_width){rs1_data[byte_width-1:0]}};
      eew16:   rs1_bcast_word = {(word_width/hword_width){rs1_data[hword_width-1:0]}};
      default: rs1_bcast_word = rs1_data;
    endcase
  end

  always_comb begin
    src1 = '0;
    if (op == op_mv_s_x) begin
      src1[word_width-1:0] = rs1_elem0;
    end else if (!is_ext && op != op_mv_x_s) begin
      src1 = (src == src_scalar) ? {(vlen/word_width){rs1_bcast_word}} : vs1_data;
    end
  end

  // extensions see the selected part repeated over the whole vector
  always_comb begin
    src2 = '0;
    case (op)
      op_zext2, op_sext2: src2 = {2{vs2_data[uop_index[0]*half +: half]}};
      op_zext4, op_sext4: src2 = {4{vs2_data[uop_index*quarter +: quarter]}};
      op_mv_x_s:          src2[word_width-1:0] = vs2_elem0;
      op_mv_s_x:          src2 = '0;
      op_merge_mv: begin
        if (!vm)
          src2 = vs2_data;
      end
      default:            src2 = vs2_data;
    endcase
  end

  always_comb begin
    is_signed   = op inside {op_min, op_max, op_sext2, op_sext4};
    take_max    = op inside {op_maxu, op_max};
    ext_factor4 = op inside {op_zext4, op_sext4};
    ignore_vma  = (op == op_merge_mv) && !vm;
    case (op)
      op_minu, op_min, op_maxu, op_max: res_sel = res_minmax;
      // vm high is vmv.v
      op_merge_mv: res_sel = vm ? res_src1 : res_merge;
      op_zext2, op_sext2, op_zext4, op_sext4: res_sel = res_extend;
      op_mv_x_s: res_sel = res_src2;
      op_mv_s_x: res_sel = res_src1;
      default:   res_sel = res_none;
    endcase
  end

endmodule

// ==== source/valu_minmax.sv ====
`timescale 1ns/1ps

module valu_minmax import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  logic [vlen-1:0] src1,
  input  logic [vlen-1:0] src2,
  input  eew_e            eew,
  input  logic            is_signed,
  input  logic            take_max,
  output logic [vlen-1:0] result
);

  // one full-width result per element size
  logic [vlen-1:0] res_by_width [3];

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int ew = (w == 0) ? byte_width :
                        (w == 1) ? hword_width : word_width;

    for (genvar i = 0; i < vlen / ew; i++) begin : g_elem
      logic [ew-1:0]    a_raw;
      logic [ew-1:0]    b_raw;
      logic signed [ew:0] a_ext;
      logic signed [ew:0] b_ext;
      logic             a_lt_b;

      assign a_raw = src2[i*ew +: ew];
      assign b_raw = src1[i*ew +: ew];

      // extra top bit makes one signed compare serve both cases
      assign a_ext = {is_signed & a_raw[ew-1], a_raw};
      assign b_ext = {is_signed & b_raw[ew-1], b_raw};

      assign a_lt_b = a_ext < b_ext;

      // min keeps src2 when smaller, max keeps src2 when not smaller
      assign res_by_width[w][i*ew +: ew] = (a_lt_b ^ take_max) ? a_raw : b_raw;
    end
  end

  always_comb begin
    case (eew)
      eew8:    result = res_by_width[0];
      eew16:   result = res_by_width[1];
      eew32:   result = res_by_width[2];
      default: result = '0;
    endcase
  end

endmodule

// ==== source/valu_extend.sv ====
`timescale 1ns/1ps

module valu_extend import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  logic [vlen-1:0] src2,
  input  eew_e            eew,
  input  logic            is_signed,
  input  logic            ext_factor4,
  output logic [vlen-1:0] result
);

  // each 32-bit output word comes from the low part of src2
  for (genvar j = 0; j < vlen / word_width; j++) begin : g_word
    logic [byte_width-1:0]  b0;
    logic [byte_width-1:0]  b1;
    logic [hword_width-1:0] h0;

    assign b0 = src2[(2*j)*byte_width +: byte_width];
    assign b1 = src2[(2*j+1)*byte_width +: byte_width];
    assign h0 = src2[j*hword_width +: hword_width];

    always_comb begin
      result[j*word_width +: word_width] = '0;
      if (ext_factor4) begin
        // 8 to 32 only
        if (eew == eew8)
          result[j*word_width +: word_width] =
            {{(word_width-byte_width){is_signed & src2[(j+1)*byte_width-1]}},
             src2[j*byte_width +: byte_width]};
      end else begin
        case (eew)
          eew8: begin
            result[j*word_width +: word_width] =
              {{byte_width{is_signed & b1[byte_width-1]}}, b1,
               {byte_width{is_signed & b0[byte_width-1]}}, b0};
          end
          eew16: begin
            result[j*word_width +: word_width] =
              {{hword_width{is_signed & h0[hword_width-1]}}, h0};
          end
          default: result[j*word_width +: word_width] = '0;
        endcase
      end
    end
  end

endmodule

// ==== source/valu_merge.sv ====
`timescale 1ns/1ps

module valu_merge import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  logic [vlen-1:0]   src1,
  input  logic [vlen-1:0]   src2,
  input  logic [vlen/8-1:0] v0_data,
  input  eew_e              eew,
  output logic [vlen-1:0]   result
);

  logic [vlen-1:0] merged [3];

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int ew = (w == 0) ? byte_width :
                        (w == 1) ? hword_width : word_width;

    // mask bit i belongs to element i
    for (genvar i = 0; i < vlen / ew; i++) begin : g_elem
      assign merged[w][i*ew +: ew] = v0_data[i] ? src1[i*ew +: ew] : src2[i*ew +: ew];
    end
  end

  always_comb begin
    case (eew)
      eew8:    result = merged[0];
      eew16:   result = merged[1];
      eew32:   result = merged[2];
      default: result = '0;
    endcase
  end

endmodule

// ==== source/valu_result_stage.sv ====
`timescale 1ns/1ps

module valu_result_stage import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  logic [rob_tag_width-1:0] rob_entry,
  input  res_sel_e                 res_sel,
  input  logic                     ignore_vma,
  input  logic [vlen-1:0]          minmax_result,
  input  logic [vlen-1:0]          extend_result,
  input  logic [vlen-1:0]          merge_result,
  input  logic [vlen-1:0]          src1,
  input  logic [vlen-1:0]          src2,
  output logic                     result_valid,
  output logic [rob_tag_width-1:0] result_rob_entry,
  output logic [vlen-1:0]          result_data,
  output logic                     result_ignore_vma
);

  logic [vlen-1:0] sel_data;

  always_comb begin
    case (res_sel)
      res_minmax: sel_data = minmax_result;
      res_merge:  sel_data = merge_result;
      res_src1:   sel_data = src1;
      res_src2:   sel_data = src2;
      res_extend: sel_data = extend_result;
      default:    sel_data = '0;
    endcase
  end

  // one register stage toward the ROB
  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid      <= 1'b0;
      result_rob_entry  <= '0;
      result_data       <= '0;
      result_ignore_vma <= 1'b0;
    end else begin
      result_valid <= uop_valid;
      // hold payload across idle cycles
      if (uop_valid) begin
        result_rob_entry  <= rob_entry;
        result_data       <= sel_data;
        result_ignore_vma <= ignore_vma;
      end
    end
  end

endmodule

// ==== source/valu_other_top.sv ====
`timescale 1ns/1ps

module valu_other_top import valu_pkg::*; #(
  parameter int vlen = 128
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     uop_valid,
  input  alu_op_e                  uop_op,
  input  src_e                     uop_src,
  input  eew_e                     uop_eew,
  input  logic                     uop_vm,
  input  logic [1:0]               uop_index,
  input  logic [rob_tag_width-1:0] rob_entry,
  input  logic [vlen-1:0]          vs1_data,
  input  logic [vlen-1:0]          vs2_data,
  input  logic [vlen/8-1:0]        v0_data,
  input  logic [xlen-1:0]          rs1_data,
  output logic                     result_valid,
  output logic [rob_tag_width-1:0] result_rob_entry,
  output logic [vlen-1:0]          result_data,
  output logic                     result_ignore_vma
);

  logic [vlen-1:0] src1;
  logic [vlen-1:0] src2;
  logic            is_signed;
  logic            take_max;
  logic            ext_factor4;
  res_sel_e        res_sel;
  logic            ignore_vma;
  logic [vlen-1:0] minmax_result;
  logic [vlen-1:0] extend_result;
  logic [vlen-1:0] merge_result;

  valu_operand_prep #(.vlen(vlen)) prep_i (
    .op(uop_op), .src(uop_src), .eew(uop_eew), .vm(uop_vm), .uop_index(uop_index),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .rs1_data(rs1_data),
    .src1(src1), .src2(src2), .is_signed(is_signed), .take_max(take_max),
    .ext_factor4(ext_factor4), .res_sel(res_sel), .ignore_vma(ignore_vma)
  );

  valu_minmax #(.vlen(vlen)) minmax_i (
    .src1(src1), .src2(src2), .eew(uop_eew), .is_signed(is_signed),
    .take_max(take_max), .result(minmax_result)
  );

  // eew is the source width here
  valu_extend #(.vlen(vlen)) extend_i (
    .src2(src2), .eew(uop_eew), .is_signed(is_signed), .ext_factor4(ext_factor4),
    .result(extend_result)
  );

  valu_merge #(.vlen(vlen)) merge_i (
    .src1(src1), .src2(src2), .v0_data(v0_data), .eew(uop_eew), .result(merge_result)
  );

  valu_result_stage #(.vlen(vlen)) result_i (
    .clk(clk), .rst(rst), .uop_valid(uop_valid), .rob_entry(rob_entry),
    .res_sel(res_sel), .ignore_vma(ignore_vma), .minmax_result(minmax_result),
    .extend_result(extend_result), .merge_result(merge_result), .src1(src1), .src2(src2),
    .result_valid(result_valid), .result_rob_entry(result_rob_entry),
    .result_data(result_data), .result_ignore_vma(result_ignore_vma)
  );

endmodule

// ==== tests/valu_clock_gen.sv ====
`timescale 1ns/1ps

module valu_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset spans three rising edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// ==== tests/valu_other_tb.sv ====
`timescale 1ns/1ps

module valu_other_tb import valu_pkg::*; ();

  localparam int vlen      = 128;
  localparam int max_tests = 64;

  logic                     clk;
  logic                     rst;
  logic                     uop_valid;
  alu_op_e                  uop_op;
  src_e                     uop_src;
  eew_e                     uop_eew;
  logic                     uop_vm;
  logic [1:0]               uop_index;
  logic [rob_tag_width-1:0] rob_entry;
  logic [vlen-1:0]          vs1_data;
  logic [vlen-1:0]          vs2_data;
  logic [vlen/8-1:0]        v0_data;
  logic [xlen-1:0]          rs1_data;
  logic                     result_valid;
  logic [rob_tag_width-1:0] result_rob_entry;
  logic [vlen-1:0]          result_data;
  logic                     result_ignore_vma;

  // pattern table, one entry per uop
  string                    names    [max_tests];
  logic [3:0]               ops      [max_tests];
  logic                     srcs     [max_tests];
  logic [1:0]               eews     [max_tests];
  logic                     vms      [max_tests];
  logic [1:0]               idxs     [max_tests];
  logic [rob_tag_width-1:0] robs     [max_tests];
  logic [vlen-1:0]          vs1s     [max_tests];
  logic [vlen-1:0]          vs2s     [max_tests];
  logic [xlen-1:0]          rs1s     [max_tests];
  logic [vlen/8-1:0]        v0s      [max_tests];
  logic [vlen-1:0]          exp_data [max_tests];
  logic                     exp_ivma [max_tests];

  int     n_tests = 0;
  int     passed  = 0;
  int     failed  = 0;
  int     stray   = 0;
  int     pending = -1;
  int     cycles  = 0;
  int     limit   = 0;
  int     gap;
  integer seed;

  valu_clock_gen clock_i (.clk(clk), .rst(rst));

  valu_other_top #(.vlen(vlen)) dut_i (
    .clk(clk), .rst(rst), .uop_valid(uop_valid), .uop_op(uop_op), .uop_src(uop_src),
    .uop_eew(uop_eew), .uop_vm(uop_vm), .uop_index(uop_index), .rob_entry(rob_entry),
    .vs1_data(vs1_data), .vs2_data(vs2_data), .v0_data(v0_data), .rs1_data(rs1_data),
    .result_valid(result_valid), .result_rob_entry(result_rob_entry),
    .result_data(result_data), .result_ignore_vma(result_ignore_vma)
  );

  task automatic load_patterns();
    int                fd;
    int                cnt;
    int                t_op;
    int                t_src;
    int                t_eew;
    int                t_vm;
    int                t_idx;
    int                t_rob;
    int                t_ivma;
    logic [vlen-1:0]   t_vs1;
    logic [vlen-1:0]   t_vs2;
    logic [vlen-1:0]   t_exp;
    logic [xlen-1:0]   t_rs1;
    logic [vlen/8-1:0] t_v0;
    string             line;
    string             t_name;
    fd = $fopen("tests/valu_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/valu_patterns.txt");
      stray++;
      return;
    end
    while (!$feof(fd) && n_tests < max_tests) begin
      line = "";
      void'($fgets(line, fd));
      // comments and blank lines
      if (line.len() < 2 || line.getc(0) == 8'h23)
        continue;
      cnt = $sscanf(line, "%s %d %d %d %d %d %d %h %h %h %h %h %d", t_name, t_op, t_src,
                    t_eew, t_vm, t_idx, t_rob, t_vs1, t_vs2, t_rs1, t_v0, t_exp, t_ivma);
      if (cnt != 13) begin
        $display("malformed pattern line: %0s", line);
        stray++;
      end else begin
        names[n_tests]    = t_name;
        ops[n_tests]      = t_op[3:0];
        srcs[n_tests]     = t_src[0];
        eews[n_tests]     = t_eew[1:0];
        vms[n_tests]      = t_vm[0];
        idxs[n_tests]     = t_idx[1:0];
        robs[n_tests]     = t_rob[rob_tag_width-1:0];
        vs1s[n_tests]     = t_vs1;
        vs2s[n_tests]     = t_vs2;
        rs1s[n_tests]     = t_rs1;
        v0s[n_tests]      = t_v0;
        exp_data[n_tests] = t_exp;
        exp_ivma[n_tests] = t_ivma[0];
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_uop(input int i);
    uop_valid = 1'b1;
    uop_op    = alu_op_e'(ops[i]);
    uop_src   = src_e'(srcs[i]);
    uop_eew   = eew_e'(eews[i]);
    uop_vm    = vms[i];
    uop_index = idxs[i];
    rob_entry = robs[i];
    vs1_data  = vs1s[i];
    vs2_data  = vs2s[i];
    v0_data   = v0s[i];
    rs1_data  = rs1s[i];
  endtask

  task automatic check_result(input int i);
    int bad;
    bad = 0;
    assert (result_valid === 1'b1) else begin
      $display("no result_valid one cycle after test %0s", names[i]);
      bad++;
    end
    assert (result_rob_entry === robs[i]) else begin
      $display("ERR %0s rob_entry expected %0d actual %0d", names[i], robs[i],
               result_rob_entry);
      bad++;
    end
    assert (result_data === exp_data[i]) else begin
      $display("ERR %0s data expected %h actual %h", names[i], exp_data[i], result_data);
      bad++;
    end
    assert (result_ignore_vma === exp_ivma[i]) else begin
      $display("ERR %0s ignore_vma expected %0b actual %0b", names[i], exp_ivma[i],
               result_ignore_vma);
      bad++;
    end
    if (bad == 0) begin
      passed++;
      $display("pass %0s", names[i]);
    end else begin
      failed++;
      $display("fail %0s", names[i]);
    end
  endtask

  task automatic check_idle();
    assert (result_valid === 1'b0) else begin
      $display("result_valid high with no uop in flight");
      stray++;
    end
  endtask

  // check what the last edge registered, then drive the next uop or idle
  task automatic next_cycle(input int idx);
    @(posedge clk);
    #1;
    if (pending >= 0)
      check_result(pending);
    else
      check_idle();
    if (idx >= 0)
      drive_uop(idx);
    else
      uop_valid = 1'b0;
    pending = idx;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("run stopped by timeout after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    uop_valid = 1'b0;
    uop_op    = op_minu;
    uop_src   = src_vector;
    uop_eew   = eew8;
    uop_vm    = 1'b1;
    uop_index = '0;
    rob_entry = '0;
    vs1_data  = '0;
    vs2_data  = '0;
    v0_data   = '0;
    rs1_data  = '0;
    seed      = 93;
    load_patterns();
    limit = 4 * n_tests + 50;
    @(negedge rst);
    next_cycle(-1);
    next_cycle(-1);
    for (int i = 0; i < n_tests; i++) begin
      // long gap midway, back to back every other block of five
      if (i == n_tests / 2)
        gap = 6;
      else if ((i / 5) % 2 == 1)
        gap = 0;
      else
        gap = {$random(seed)} % 3;
      repeat (gap) next_cycle(-1);
      next_cycle(i);
    end
    next_cycle(-1);
    next_cycle(-1);
    next_cycle(-1);
    $display("%0d tests, %0d passed, %0d failed, %0d other errors", n_tests, passed,
             failed, stray);
    if (failed == 0 && stray == 0 && n_tests > 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/valu_patterns.txt ====
# name op src eew vm uop_index rob vs1 vs2 rs1 v0 exp_data exp_ignore_vma
# op, src and eew as decimal enum codes; vectors, rs1 and v0 in hex, msb first
minu_e8_vv 0 0 0 1 0 0 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 017f01027f007f00017f01027f007f00 0
min_e8_vv 1 0 0 1 0 1 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 808001fe80ff80ff808001fe80ff80ff 0
maxu_e8_vv 2 0 0 1 0 2 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 80807ffe80ff80ff80807ffe80ff80ff 0
max_e8_vv 3 0 0 1 0 3 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 017f7f027f007f00017f7f027f007f00 0
minu_e16_vv 0 0 1 1 0 4 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 018001fe7fff7fff018001fe7fff7fff 0
min_e32_vv 1 0 2 1 0 5 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 807f01fe80007fff807f01fe80007fff 0
minu_e32_vv 0 0 2 1 0 6 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 0000 01807f027fff800001807f027fff8000 0
maxu_e8_vx 2 1 0 1 0 7 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 12345680 0000 808080fe80ff8080808080fe80ff8080 0
min_e8_vx 1 1 0 1 0 0 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 000000ff 0000 80fffffeffff80ff80fffffeffff80ff 0
max_e16_vx 3 1 1 1 0 1 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 abcd8001 0000 807f01fe7fff8001807f01fe7fff8001 0
maxu_e32_vx 2 1 2 1 0 2 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 7fffffff 0000 807f01fe7fffffff807f01fe7fffffff 0
merge_e8_vvm 4 0 0 0 0 3 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 00000000 a5c3 017f7ffe7f0080ff018001fe7fff7fff 1
merge_e32_vxm 4 1 2 0 0 4 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 deadbeef fff5 807f01fedeadbeef807f01fedeadbeef 1
mv_v_v_e32 4 0 2 1 0 5 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 deadbeef a5c3 01807f0280007fff01807f0280007fff 0
mv_v_x_e16 4 1 1 1 0 6 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 1234a55a a5c3 a55aa55aa55aa55aa55aa55aa55aa55a 0
zext2_e8_i0 5 0 0 1 0 7 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 00780069005a004b003c002d001e000f 0
sext2_e8_i1 6 0 0 1 1 0 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 fff0ffe1ffd2ffc3ffb4ffa5ff96ff87 0
zext2_e16_i0 5 0 1 1 0 1 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 0000786900005a4b00003c2d00001e0f 0
sext2_e16_i1 6 0 1 1 1 2 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 fffff0e1ffffd2c3ffffb4a5ffff9687 0
zext4_e8_i0 7 0 0 1 0 3 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 0000003c0000002d0000001e0000000f 0
sext4_e8_i1 8 0 0 1 1 4 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 00000078000000690000005a0000004b 0
sext4_e8_i2 8 0 0 1 2 5 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 ffffffb4ffffffa5ffffff96ffffff87 0
zext4_e8_i3 7 0 0 1 3 6 00000000000000000000000000000000 f0e1d2c3b4a5968778695a4b3c2d1e0f 00000000 0000 000000f0000000e1000000d2000000c3 0
mv_x_s_e16 9 0 1 1 0 7 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 deadbeef 0000 00000000000000000000000000008000 0
mv_s_x_e8 10 1 0 1 0 0 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 12345680 0000 00000000000000000000000000000080 0
mv_s_x_e32 10 1 2 1 0 1 01807f0280007fff01807f0280007fff 807f01fe7fff8000807f01fe7fff8000 deadbeef 0000 000000000000000000000000deadbeef 0

// ==== filelist.f ====
source/valu_pkg.sv
source/valu_operand_prep.sv
source/valu_minmax.sv
source/valu_extend.sv
source/valu_merge.sv
source/valu_result_stage.sv
source/valu_other_top.sv
tests/valu_clock_gen.sv
tests/valu_other_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall
TOP        := valu_other_tb
RTL_TOP    := valu_other_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
RTL_FILES  := $(shell grep '^source/' $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard source/*.sv tests/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
